// ==== files.f ====
logic/limn_pkg.sv
logic/inst_decode.sv
logic/exec_unit.sv
logic/reg_file.sv
logic/core_sequencer.sv
logic/limn_core.sv
tb/core_checker.sv
tb/tb_core.sv

// ==== logic/core_sequencer.sv ====
`timescale 1ns/1ps

module core_sequencer
    import limn_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  decoded_t     dec,
    input  exec_result_t res,
    input  word_t        data_in,
    input  logic         rdy,
    output word_t        pc,
    output logic         wr_en,
    output reg_idx_t     wr_idx,
    output word_t        wr_data,
    output word_t        addr,
    output word_t        data_out,
    output logic         we,
    output logic         ce
);

    core_state_t state;
    reg_idx_t    ld_idx; // Load target, held through READ

    ////////////////////////////////////////////////////////////////////////////
    // Bus FSM
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FETCH;
            pc    <= RESET_PC;
            addr  <= RESET_PC; // First fetch goes out right after reset
            ce    <= 1'b1;
            we    <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    if (rdy) begin // Instruction now on data_in
                        state <= EXECUTE;
                        ce    <= 1'b0;
                    end
                end
                EXECUTE: begin
                    pc <= res.next_pc; // PC+4 for loads and stores
                    ce <= 1'b1;
                    if (!res.trap && dec.cls == LOAD) begin
                        state <= READ;
                        addr  <= res.mem_addr;
                    end else if (!res.trap && dec.cls == STORE) begin
                        state <= WRITE;
                        addr  <= res.mem_addr;
                        we    <= 1'b1;
                    end else begin
                        state <= FETCH; // ALU, branch, JAL, NOP, trap
                        addr  <= res.next_pc;
                    end
                end
                READ, WRITE: begin
                    if (rdy) begin // Transfer done, fetch next
                        state <= FETCH;
                        we    <= 1'b0;
                        addr  <= pc;
                    end
                end
                default: state <= FETCH;
            endcase
        end
    end

    // Payload captured in EXECUTE, stable for the whole transfer
    always_ff @(posedge clk) begin
        if (state == EXECUTE) begin
            data_out <= res.st_data;
            ld_idx   <= dec.rd;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Writeback
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        if (state == READ) begin
            wr_en   = rdy;      // Load data valid with rdy
            wr_idx  = ld_idx;
            wr_data = data_in;
        end else begin
            wr_en   = (state == EXECUTE) && res.wb_en;
            wr_idx  = dec.rd;
            wr_data = res.wb_val;
        end
    end

    // Write strobe only during the store transfer
    a_we_in_write: assert property (@(posedge clk) disable iff (rst)
        we |-> state == WRITE);

    // Misaligned targets must have trapped in execute
    a_addr_aligned: assert property (@(posedge clk) disable iff (rst)
        ce |-> addr[1:0] == 2'b00);

endmodule

// ==== logic/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit
    import limn_pkg::*;
(
    input  decoded_t     dec,
    input  word_t        ra_val,
    input  word_t        rb_val,
    input  word_t        pc,
    output exec_result_t res
);

    word_t imm_ext;
    word_t alu_val;
    word_t pc_inc;
    word_t br_target;
    word_t jal_target;
    logic  br_cond;

    assign imm_ext    = {16'b0, dec.imm16}; // Zero-extended ALU operand
    assign pc_inc     = pc + 32'd4;
    assign br_target  = pc + {{9{dec.imm21[20]}}, dec.imm21, 2'b00};
    assign jal_target = {pc[31], dec.imm29, 2'b00}; // Stays in the same half

    always_comb begin
        case (dec.alu_op)
            ALU_LUI:   alu_val = ra_val | {dec.imm16, 16'b0};
            ALU_ORI:   alu_val = ra_val | imm_ext;
            ALU_XORI:  alu_val = ra_val ^ imm_ext;
            ALU_ANDI:  alu_val = ra_val & imm_ext;
            ALU_SLTIS: alu_val = {31'b0, $signed(ra_val) < $signed(imm_ext)};
            ALU_SLTI:  alu_val = {31'b0, ra_val < imm_ext};
            ALU_SUBI:  alu_val = ra_val - imm_ext;
            default:   alu_val = ra_val + imm_ext; // ADDI
        endcase
    end

    always_comb begin
        case (dec.br_kind)
            BR_EQ:   br_cond = (ra_val == '0);
            BR_NE:   br_cond = (ra_val != '0);
            default: br_cond = ra_val[31]; // BLT, sign of ra
        endcase
    end

    always_comb begin
        res          = '0;
        res.mem_addr = ra_val + {14'b0, dec.imm16, 2'b00}; // Long size scales by 4
        res.st_data  = dec.st_imm ? {27'b0, dec.imm5} : rb_val;
        res.next_pc  = pc_inc;
        case (dec.cls)
            NOP: res.next_pc = pc;
            ALU_IMM: begin
                res.wb_val = alu_val;
                res.wb_en  = 1'b1;
            end
            BRANCH: begin
                res.taken = br_cond;
                if (br_cond) res.next_pc = br_target;
            end
            JAL: begin
                res.taken   = 1'b1;
                res.next_pc = jal_target;
                res.wb_val  = pc_inc; // Link value
                res.wb_en   = dec.link;
            end
            LOAD, STORE: res.trap = (res.mem_addr[1:0] != 2'b00);
            default: res.trap = 1'b1;
        endcase
        if (res.trap) begin // No writeback, redirect to vector
            res.wb_en   = 1'b0;
            res.next_pc = TRAP_VEC;
        end
    end

endmodule

// ==== logic/inst_decode.sv ====
`timescale 1ns/1ps

module inst_decode
    import limn_pkg::*;
(
    input  word_t    inst,
    output decoded_t dec
);

    opcode_t    opc;
    logic [1:0] tsz;

    assign opc = inst[5:0];
    assign tsz = inst[4:3]; // Transfer size of the simple MOV forms

    ////////////////////////////////////////////////////////////////////////////
    // Field split and classification
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        dec         = '0;
        dec.cls     = INVALID;
        dec.alu_op  = inst[5:3];
        dec.rd      = inst[10:6];
        dec.ra      = inst[15:11]; // ALU and load source
        dec.rb      = inst[15:11];
        dec.imm16   = inst[31:16];
        dec.imm21   = inst[31:11];
        dec.imm29   = inst[31:3];
        dec.imm5    = inst[15:11];
        dec.br_kind = BR_EQ;

        casez (opc)
            6'b000000: dec.cls = NOP; // Internal no-op, PC holds
            OPC_BEQ, OPC_BNE, OPC_BLT: begin
                dec.cls = BRANCH;
                dec.ra  = inst[10:6]; // Tested register sits in the rd slot
                if (opc == OPC_BNE) begin
                    dec.br_kind = BR_NE;
                end else if (opc == OPC_BLT) begin
                    dec.br_kind = BR_LT;
                end
            end
            6'b???11?: begin
                dec.cls  = JAL;
                dec.rd   = REG_LR;
                dec.link = inst[0];
            end
            6'b???100: dec.cls = ALU_IMM;
            6'b1??011: begin // MOV rd,[ra+imm16]
                if (tsz == TSZ_LONG) dec.cls = LOAD; // Sub-word loads trap
            end
            6'b???010: begin // MOV [ra+imm16],rb or imm5
                dec.ra     = inst[10:6];
                dec.st_imm = ~inst[5];
                if (tsz == TSZ_LONG) dec.cls = STORE;
            end
            default: dec.cls = INVALID; // JALR, priv group, reg ALU and the rest
        endcase
    end

endmodule

// ==== logic/limn_core.sv ====
`timescale 1ns/1ps

module limn_core
    import limn_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    output word_t addr,
    output word_t data_out,
    input  word_t data_in,
    input  logic  rdy,
    output logic  we,
    output logic  ce
);

    decoded_t     dec;
    exec_result_t res;
    word_t        ra_val;
    word_t        rb_val;
    word_t        pc;
    logic         wr_en;
    reg_idx_t     wr_idx;
    word_t        wr_data;

    // Instruction word is held on data_in through EXECUTE
    inst_decode i_decode (.inst(data_in), .dec(dec));

    reg_file i_regs (
        .clk(clk), .ra_idx(dec.ra), .rb_idx(dec.rb), .wr_idx(wr_idx),
        .ra_val(ra_val), .rb_val(rb_val), .wr_en(wr_en), .wr_data(wr_data)
    );

    exec_unit i_exec (.dec(dec), .ra_val(ra_val), .rb_val(rb_val), .pc(pc), .res(res));

    core_sequencer i_seq (
        .clk(clk), .rst(rst), .dec(dec), .res(res), .data_in(data_in), .rdy(rdy),
        .pc(pc), .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
        .addr(addr), .data_out(data_out), .we(we), .ce(ce)
    );

endmodule

// ==== logic/limn_pkg.sv ====
package limn_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////
    typedef logic [31:0] word_t;    // Data, address and instruction word
    typedef logic [4:0]  reg_idx_t; // Register number
    typedef logic [15:0] imm16_t;
    typedef logic [20:0] imm21_t;   // Branch offset in words
    typedef logic [28:0] imm29_t;   // JAL target in words
    typedef logic [2:0]  alu_op_t;  // Opcode bits 5:3 of the immediate group
    typedef logic [5:0]  opcode_t;  // Low six opcode bits

    localparam int       NUM_REGS = 32;
    localparam word_t    RESET_PC = 32'hFFFE_0000;
    localparam word_t    TRAP_VEC = 32'hFFFE_1000; // Invalid opcode, misaligned access
    localparam reg_idx_t REG_LR   = 5'd31;

    // Branch opcodes
    localparam opcode_t OPC_BEQ = 6'b111101;
    localparam opcode_t OPC_BNE = 6'b110101;
    localparam opcode_t OPC_BLT = 6'b101101;

    localparam logic [1:0] TSZ_LONG = 2'b01; // Size field of a 32-bit MOV

    // Immediate ALU group, 0 is LUI
    localparam alu_op_t ALU_LUI   = 3'd0;
    localparam alu_op_t ALU_ORI   = 3'd1;
    localparam alu_op_t ALU_XORI  = 3'd2;
    localparam alu_op_t ALU_ANDI  = 3'd3;
    localparam alu_op_t ALU_SLTIS = 3'd4;
    localparam alu_op_t ALU_SLTI  = 3'd5;
    localparam alu_op_t ALU_SUBI  = 3'd6;
    localparam alu_op_t ALU_ADDI  = 3'd7;

    ////////////////////////////////////////////////////////////////////////////
    // Types shared between decode, execute and sequencer
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {NOP, ALU_IMM, LOAD, STORE, BRANCH, JAL, INVALID} inst_class_t;
    typedef enum logic [1:0] {FETCH, EXECUTE, READ, WRITE} core_state_t;
    typedef enum logic [1:0] {BR_EQ, BR_NE, BR_LT} br_kind_t;

    typedef struct packed {
        inst_class_t cls;
        alu_op_t     alu_op;
        reg_idx_t    rd;      // Writeback target, r31 for JAL
        reg_idx_t    ra;      // Base or compared register
        reg_idx_t    rb;      // Store data register
        imm16_t      imm16;
        imm21_t      imm21;
        imm29_t      imm29;
        logic [4:0]  imm5;    // Immediate store value
        br_kind_t    br_kind;
        logic        link;    // JAL writes r31
        logic        st_imm;  // Store imm5 instead of rb
    } decoded_t;

    typedef struct packed {
        word_t wb_val;
        logic  wb_en;
        logic  taken;    // Branch or JAL redirect
        word_t next_pc;
        word_t mem_addr;
        word_t st_data;
        logic  trap;
    } exec_result_t;

endpackage

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps

module reg_file
    import limn_pkg::*;
(
    input  logic     clk,
    input  reg_idx_t ra_idx,
    input  reg_idx_t rb_idx,
    input  reg_idx_t wr_idx,
    output word_t    ra_val,
    output word_t    rb_val,
    input  logic     wr_en,
    input  word_t    wr_data
);

    word_t regs [1:NUM_REGS-1]; // r0 has no storage

    always_ff @(posedge clk) begin
        if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Combinational read with r0 forced to zero
    assign ra_val = (ra_idx == '0) ? '0 : regs[ra_idx];
    assign rb_val = (rb_idx == '0) ? '0 : regs[rb_idx];

    // Last write reads back on port a and r0 stays zero
    a_wr_readback: assert property (@(posedge clk)
        wr_en ##1 (ra_idx == $past(wr_idx)) |->
            ra_val == (($past(wr_idx) == '0) ? '0 : $past(wr_data)));

endmodule

// ==== tb/core_checker.sv ====
`timescale 1ns/1ps

module core_checker
    import limn_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  ce,
    input  logic  we,
    input  logic  rdy,
    input  word_t addr,
    input  word_t data_out,
    input  word_t loop_addr, // Fetch address of the closing self-loop
    output logic  done,
    output int    errors
);

    word_t exp_q [$]; // Address and data pairs from the model
    word_t act_q [$]; // Same layout taken off the bus
    string test_name;
    int    base_errors; // Error count when the test started
    logic  rst_q = 1'b0;

    initial begin
        done        = 1'b0;
        errors      = 0;
        base_errors = 0;
    end

    task automatic start_test(input string name);
        test_name   = name;
        base_errors = errors;
        exp_q.delete();
        act_q.delete();
        done = 1'b0;
    endtask

    task automatic expect_store(input word_t a, input word_t d);
        exp_q.push_back(a);
        exp_q.push_back(d);
    endtask

    task automatic compare_stores();
        int bad;
        bad = 0;
        if (act_q.size() != exp_q.size()) begin
            $display("Test %s made %0d stores where %0d were expected",
                     test_name, act_q.size() / 2, exp_q.size() / 2);
            bad++;
        end
        for (int i = 0; i < exp_q.size() && i < act_q.size(); i++) begin
            if (act_q[i] !== exp_q[i]) begin
                $display("CHECK FAILED %s: store %0d %s expected %h actual %h", test_name,
                         i / 2, (i % 2) ? "data" : "addr", exp_q[i], act_q[i]);
                bad++;
            end
        end
        errors += bad;
        $display("Test %-14s %s", test_name, (errors == base_errors) ? "passed" : "FAILED");
    endtask

    always @(posedge clk) begin
        rst_q <= rst;
        // First command out of reset
        if (rst_q && !rst && (ce !== 1'b1 || we !== 1'b0 || addr !== RESET_PC)) begin
            $display("CHECK FAILED %s: reset fetch expected ce=1 we=0 addr=%h actual %b %b %h",
                     test_name, RESET_PC, ce, we, addr);
            errors++;
        end
        if (!rst && !done && ce && rdy) begin
            if (we) begin // Completed store
                act_q.push_back(addr);
                act_q.push_back(data_out);
            end else if (addr == loop_addr) begin
                compare_stores();
                done = 1'b1;
            end
        end
    end

endmodule

// ==== tb/tb_core.sv ====
`timescale 1ns/1ps

module tb_core
    import limn_pkg::*;
();

    logic  clk, rst, rdy, we, ce, chk_done;
    word_t addr, data_out, data_in, loop_addr, gpc;
    word_t mem [0:16383];     // 64 KiB window at FFFE0000
    word_t ref_mem [0:16383]; // Model copy
    int    chk_errors, n_tests, n_words, wd_count, wd_limit;
    string cur_name;

    limn_core i_dut (.clk(clk), .rst(rst), .addr(addr), .data_out(data_out),
                     .data_in(data_in), .rdy(rdy), .we(we), .ce(ce));

    core_checker i_chk (.clk(clk), .rst(rst), .ce(ce), .we(we), .rdy(rdy), .addr(addr),
                        .data_out(data_out), .loop_addr(loop_addr), .done(chk_done),
                        .errors(chk_errors));

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic word_t fill_word(word_t a);
        return a ^ 32'h6d2b_79f5; // Whole address in the pattern
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Memory with random rdy and writes on ce & we & rdy
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (ce && we && rdy && addr[31:16] == 16'hFFFE) mem[addr[15:2]] <= data_out;
        #1;
        rdy <= ($urandom % 4) != 0;
        if (ce && !we) data_in <= (addr[31:16] == 16'hFFFE) ? mem[addr[15:2]] : fill_word(addr);
    end

    always @(posedge clk) begin // Watchdog
        if (rst || chk_done) begin
            wd_count = 0;
        end else begin
            wd_count++;
            if (wd_count > wd_limit) begin
                $display("Test %s timed out after %0d cycles", cur_name, wd_limit);
                $display("FAIL: see errors above");
                $finish;
            end
        end
    end

    // Instruction encoders
    function automatic word_t alu_word(alu_op_t op, reg_idx_t rd, reg_idx_t ra, imm16_t k);
        return {k, ra, rd, op, 3'b100};
    endfunction
    function automatic word_t branch_word(opcode_t opc, reg_idx_t ra, int off);
        return {off[20:0], ra, opc};
    endfunction
    function automatic word_t jal_word(word_t target, logic link);
        return {target[30:2], 2'b11, link};
    endfunction
    function automatic word_t load_word(reg_idx_t rd, reg_idx_t ra, imm16_t k);
        return {k, ra, rd, 6'b101011};
    endfunction
    function automatic word_t store_word(reg_idx_t ra, reg_idx_t rb, imm16_t k);
        return {k, rb, ra, 6'b101010};
    endfunction
    function automatic word_t store_imm_word(reg_idx_t ra, logic [4:0] v, imm16_t k);
        return {k, v, ra, 6'b001010};
    endfunction

    task automatic emit(input word_t w);
        mem[gpc[15:2]]     = w;
        ref_mem[gpc[15:2]] = w;
        gpc += 4;
        n_words++;
    endtask

    function automatic word_t rand_alu(int rd_min); // Targets stay below r10
        return alu_word($urandom % 8, rd_min + $urandom % (9 - rd_min), $urandom % 9, $urandom);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Program generator
    ////////////////////////////////////////////////////////////////////////////
    task automatic build(input int kind);
        opcode_t bops [3] = '{OPC_BEQ, OPC_BNE, OPC_BLT};
        word_t   v;
        int      k;
        emit(alu_word(ALU_LUI, 10, 0, 16'hFFFE)); // r10 is the window base
        for (int r = 1; r <= 9; r++) begin        // r1..r8 and r31 with some zero
            v = ($urandom % 4 == 0) ? '0 : $urandom;
            emit(alu_word(ALU_LUI, (r == 9) ? 31 : r, 0, v[31:16]));
            emit(alu_word(ALU_ORI, (r == 9) ? 31 : r, (r == 9) ? 31 : r, v[15:0]));
        end
        case (kind)
            1: begin
                repeat (24) emit(rand_alu(0));
                emit(store_word(10, 0, 16'h1000)); // r0 slot
            end
            2: repeat (16) case ($urandom % 3)
                0: emit(store_word(10, $urandom % 9, 16'h2000 + $urandom % 8));
                1: emit(store_imm_word(10, $urandom, 16'h2000 + $urandom % 8));
                default: emit(load_word(1 + $urandom % 8, 10, 16'h2000 + $urandom % 8));
            endcase
            3: repeat (8) begin
                emit(rand_alu(1));
                if ($urandom % 2) begin // Forward skip of k words
                    k = 1 + $urandom % 3;
                    emit(branch_word(bops[$urandom % 3], 1 + $urandom % 8, k + 1));
                    repeat (k) emit(rand_alu(1));
                end else begin // Backward branch entered once by a trampoline
                    emit(branch_word(OPC_BEQ, 0, 3));
                    emit(rand_alu(1));
                    emit(branch_word(OPC_BEQ, 0, 2));
                    emit(branch_word(bops[$urandom % 3], 1 + $urandom % 8, -2));
                end
            end
            4: begin
                repeat (4) begin
                    emit(rand_alu(1));
                    emit(jal_word(gpc + 12, $urandom % 2));
                    emit(rand_alu(1));
                    emit(rand_alu(1));
                end
                emit(alu_word(ALU_ORI, 8, 31, 0)); // r31 lands in a stored slot
            end
            5, 6: begin
                repeat (3) emit(rand_alu(1));
                if (kind == 5) begin
                    emit(alu_word(ALU_ORI, 9, 10, 1 + $urandom % 3));
                    emit(store_word(9, 1 + $urandom % 8, 16'h2000));
                end else begin
                    v      = $urandom;
                    v[5:0] = 6'b000001; // No such opcode
                    emit(v);
                end
                gpc = TRAP_VEC;
                emit(store_imm_word(10, 5'h15, 16'h1010)); // Handler marker
            end
            default: ;
        endcase
        for (int r = 1; r <= 8; r++) emit(store_word(10, r, 16'h1000 + r));
        emit(jal_word(gpc, 1'b0)); // Self-loop
    endtask

    function automatic word_t alu_ref(logic [2:0] op, word_t x, word_t k);
        case (op)
            0: return x | (k << 16);
            1: return x | k;
            2: return x ^ k;
            3: return x & k;
            4: return word_t'($signed(x) < $signed(k));
            5: return word_t'(x < k);
            6: return x - k;
            default: return x + k;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // ISA reference model feeding the checker its expected stores
    ////////////////////////////////////////////////////////////////////////////
    task automatic run_model();
        word_t rf [0:31];
        word_t pc, npc, w, a, d;
        rf = '{default: '0};
        pc = RESET_PC;
        for (int step = 0; step < 4000; step++) begin
            w   = ref_mem[pc[15:2]];
            npc = pc + 4;
            a   = {14'b0, w[31:16], 2'b00}; // Word-scaled offset
            if (w[5:0] == OPC_BEQ || w[5:0] == OPC_BNE || w[5:0] == OPC_BLT) begin
                d = rf[w[10:6]];
                if ((w[5:0] == OPC_BEQ && d == 0) || (w[5:0] == OPC_BNE && d != 0) ||
                    (w[5:0] == OPC_BLT && d[31]))
                    npc = pc + {{9{w[31]}}, w[31:11], 2'b00};
            end else if (w[2:1] == 2'b11) begin
                if (w[0]) rf[31] = pc + 4;
                npc = {pc[31], w[31:3], 2'b00};
                if (npc == pc) begin
                    loop_addr = pc;
                    break;
                end
            end else if (w[2:0] == 3'b100) begin
                rf[w[10:6]] = alu_ref(w[5:3], rf[w[15:11]], {16'b0, w[31:16]});
            end else if (w[5:0] == 6'b101011) begin
                a += rf[w[15:11]];
                if (a[1:0] != 0) npc = TRAP_VEC;
                else rf[w[10:6]] = (a[31:16] == 16'hFFFE) ? ref_mem[a[15:2]] : fill_word(a);
            end else if (w[5:0] == 6'b101010 || w[5:0] == 6'b001010) begin
                a += rf[w[10:6]];
                d = w[5] ? rf[w[15:11]] : {27'b0, w[15:11]};
                if (a[1:0] != 0) begin
                    npc = TRAP_VEC;
                end else begin
                    ref_mem[a[15:2]] = d;
                    i_chk.expect_store(a, d);
                end
            end else begin
                npc = TRAP_VEC;
            end
            rf[0] = '0;
            pc    = npc;
        end
    endtask

    task automatic run_test(input int kind, input string name);
        @(posedge clk);
        #1 rst = 1'b1;
        cur_name = name;
        for (int i = 0; i < 16384; i++) begin
            mem[i]     = fill_word({16'hFFFE, i[13:0], 2'b00});
            ref_mem[i] = mem[i];
        end
        gpc     = RESET_PC;
        n_words = 0;
        build(kind);
        i_chk.start_test(name);
        run_model();
        wd_limit = 40 * n_words;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        wait (chk_done);
        n_tests++;
    endtask

    initial begin
        rst      = 1'b1;
        rdy      = 1'b0;
        data_in  = '0;
        n_tests  = 0;
        wd_limit = 1000;
        void'($urandom(32'hfba29382));
        run_test(0, "reset_fetch");
        run_test(1, "alu_imm");
        run_test(2, "load_store");
        run_test(3, "branches");
        run_test(4, "jal_link");
        run_test(5, "trap_misalign");
        run_test(6, "trap_invalid");
        $display("Tests run: %0d, checks failed: %0d", n_tests, chk_errors);
        if (chk_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
